// ==== vlog.f ====
+incdir+rtl
rtl/ip_hdr_pkg.sv
rtl/ip_demux_pkg.sv
rtl/ip_demux_frame_ctrl.sv
rtl/ip_demux_payload_path.sv
rtl/ip_demux.sv
dv/ip_demux_checker.sv
dv/ip_demux_tb.sv

// ==== dv/ip_demux_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench for the IP frame demultiplexer, runs a table of frames with
// random header values, payload bytes and sink back-pressure
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "ip_demux_cfg.svh"

module ip_demux_tb;

    import ip_hdr_pkg::*;
    import ip_demux_pkg::*;

    localparam int NUM_ENTRIES  = 12;
    localparam int MAX_LEN      = 12;
    localparam int RESET_CYCLES = 5;
    localparam int TIMEOUT_NS   = (NUM_ENTRIES * (MAX_LEN * 4 + 20) + RESET_CYCLES) * 10;

    typedef struct packed {
        logic       en;
        port_sel_t  sel;
        logic [3:0] len;
        logic       user;
        logic       bp;
    } entry_t;

    // enable, select, payload length, tuser on last beat, sink back-pressure
    entry_t tbl [NUM_ENTRIES] = '{
        {1'b1, 2'd0, 4'd4,  1'b0, 1'b0},
        {1'b1, 2'd1, 4'd1,  1'b1, 1'b0},
        {1'b1, 2'd2, 4'd12, 1'b0, 1'b1},
        {1'b1, 2'd2, 4'd5,  1'b1, 1'b1},
        {1'b0, 2'd3, 4'd3,  1'b0, 1'b0},
        {1'b1, 2'd0, 4'd2,  1'b1, 1'b1},
        {1'b1, 2'd0, 4'd3,  1'b0, 1'b1},
        {1'b1, 2'd1, 4'd9,  1'b0, 1'b1},
        {1'b1, 2'd1, 4'd1,  1'b0, 1'b0},
        {1'b1, 2'd3, 4'd12, 1'b1, 1'b1},
        {1'b0, 2'd2, 4'd8,  1'b1, 1'b1},
        {1'b1, 2'd2, 4'd6,  1'b0, 1'b0}
    };

    logic          clk;
    logic          rst;
    logic          enable;
    port_sel_t     select;
    logic          in_hdr_valid, in_hdr_ready;
    eth_type_t     in_eth_type, out_eth_type;
    ip_len_t       in_ip_length, out_ip_length;
    ip_proto_t     in_ip_protocol, out_ip_protocol;
    ip_addr_t      in_ip_source_ip, in_ip_dest_ip, out_ip_source_ip, out_ip_dest_ip;
    payload_byte_t in_payload_tdata, out_payload_tdata;
    logic          in_payload_tvalid, in_payload_tready, in_payload_tlast, in_payload_tuser;
    logic          out_payload_tlast, out_payload_tuser;
    port_mask_t    out_hdr_valid, out_hdr_ready, out_payload_tvalid, out_payload_tready;

    eth_type_t     exp_eth [NUM_ENTRIES];
    ip_len_t       exp_len [NUM_ENTRIES];
    ip_proto_t     exp_proto [NUM_ENTRIES];
    ip_addr_t      exp_src [NUM_ENTRIES];
    ip_addr_t      exp_dst [NUM_ENTRIES];
    payload_byte_t exp_data [NUM_ENTRIES][MAX_LEN];
    logic          hdr_done [NUM_ENTRIES];
    int            value_errors = 0;
    int            protocol_errors = 0;
    logic          cap_en;
    port_sel_t     cap_sel;
    port_mask_t    cap_busy;

    always #5 clk = ~clk;

    ip_demux i_ip_demux (.*);

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        value_errors++;
        $display("ERROR %0t ns: %s expected %0h got %0h", $time, name, exp, act);
    endtask

    task automatic check_port(input string name, input port_sel_t exp, input port_sel_t act);
        if (exp !== act)
            report_mismatch(name, exp, act);
    endtask

    task automatic check_addr(input string name, input ip_addr_t exp, input ip_addr_t act);
        if (exp !== act)
            report_mismatch(name, exp, act);
    endtask

    task automatic check_field16(input string name, input ip_len_t exp, input ip_len_t act);
        if (exp !== act)
            report_mismatch(name, exp, act);
    endtask

    task automatic check_byte(input string name, input payload_byte_t exp,
                              input payload_byte_t act);
        if (exp !== act)
            report_mismatch(name, exp, act);
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act)
            report_mismatch(name, exp, act);
    endtask

    // highest raised output in a mask
    function automatic port_sel_t port_of(input port_mask_t m);
        port_sel_t p;
        p = '0;
        for (int i = 0; i < `IP_DEMUX_NUM_OUTPUTS; i++) begin
            if (m[i]) begin
                p = port_sel_t'(i);
            end
        end
        return p;
    endfunction

    // a header may only be taken while enabled and with the requested port idle
    always @(posedge clk) begin
        if (!rst && in_hdr_ready && (!cap_en || cap_busy[cap_sel])) begin
            protocol_errors++;
            $display("header taken at %0t ns while port %0d was disabled or busy",
                     $time, cap_sel);
        end
        cap_en   = enable;
        cap_sel  = select;
        cap_busy = out_hdr_valid | out_payload_tvalid;
    end

    task automatic send_frame(input int k);
        port_mask_t seen;
        // a different port waits for the previous header to be taken
        if (k > 0 && tbl[k].sel != tbl[k-1].sel) begin
            wait (hdr_done[k-1]);
            @(posedge clk);
            #1;
        end
        enable          = tbl[k].en;
        select          = tbl[k].sel;
        in_eth_type     = exp_eth[k];
        in_ip_length    = exp_len[k];
        in_ip_protocol  = exp_proto[k];
        in_ip_source_ip = exp_src[k];
        in_ip_dest_ip   = exp_dst[k];
        in_hdr_valid    = 1'b1;
        if (!tbl[k].en) begin
            repeat (20) begin
                seen = out_hdr_valid;
                @(posedge clk);
                #1;
                check_bit("in_hdr_ready", 1'b0, in_hdr_ready);
                check_bit("out_hdr_valid rise", 1'b0, |(out_hdr_valid & ~seen));
            end
            enable = 1'b1;
        end
        @(posedge clk);
        while (!in_hdr_ready) @(posedge clk);
        #1 in_hdr_valid = 1'b0;
        for (int i = 0; i < tbl[k].len; i++) begin
            in_payload_tdata  = exp_data[k][i];
            in_payload_tlast  = (i == tbl[k].len - 1);
            in_payload_tuser  = (i == tbl[k].len - 1) ? tbl[k].user : 1'b0;
            in_payload_tvalid = 1'b1;
            @(posedge clk);
            while (!in_payload_tready) @(posedge clk);
            #1;
        end
        in_payload_tvalid = 1'b0;
        in_payload_tlast  = 1'b0;
        in_payload_tuser  = 1'b0;
    endtask

    task automatic take_frame(input int k);
        port_sel_t sel;
        int        hold;
        int        idx;
        logic      done;
        sel  = tbl[k].sel;
        hold = tbl[k].bp ? 3 + $urandom % 8 : 0;
        done = 1'b0;
        while (!done) begin
            out_hdr_ready[sel] = (hold == 0);
            @(posedge clk);
            if (out_hdr_valid[sel] && out_hdr_ready[sel]) begin
                check_port("out_hdr_valid port", sel, port_of(out_hdr_valid));
                check_field16("out_eth_type", exp_eth[k], out_eth_type);
                check_field16("out_ip_length", exp_len[k], out_ip_length);
                check_byte("out_ip_protocol", exp_proto[k], out_ip_protocol);
                check_addr("out_ip_source_ip", exp_src[k], out_ip_source_ip);
                check_addr("out_ip_dest_ip", exp_dst[k], out_ip_dest_ip);
                done = 1'b1;
            end else if (out_hdr_valid[sel] && hold > 0) begin
                hold--;
            end
            #1;
        end
        out_hdr_ready[sel] = 1'b0;
        hdr_done[k] = 1'b1;
        idx = 0;
        while (idx < tbl[k].len) begin
            out_payload_tready[sel] = tbl[k].bp ? (($urandom % 2) == 1) : 1'b1;
            @(posedge clk);
            if (out_payload_tvalid[sel] && out_payload_tready[sel]) begin
                check_port("out_payload_tvalid port", sel, port_of(out_payload_tvalid));
                check_byte("out_payload_tdata", exp_data[k][idx], out_payload_tdata);
                check_bit("out_payload_tlast", idx == tbl[k].len - 1, out_payload_tlast);
                check_bit("out_payload_tuser", (idx == tbl[k].len - 1) && tbl[k].user,
                          out_payload_tuser);
                idx++;
            end
            #1;
        end
        out_payload_tready[sel] = 1'b0;
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: frames still in flight after %0d ns", TIMEOUT_NS);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        int assert_errors;
        void'($urandom(82946));
        clk = 1'b0;
        rst = 1'b1;
        enable = 1'b1;
        select = '0;
        in_hdr_valid = 1'b0;
        in_eth_type = '0;
        in_ip_length = '0;
        in_ip_protocol = '0;
        in_ip_source_ip = '0;
        in_ip_dest_ip = '0;
        in_payload_tdata = '0;
        in_payload_tvalid = 1'b0;
        in_payload_tlast = 1'b0;
        in_payload_tuser = 1'b0;
        out_hdr_ready = '0;
        out_payload_tready = '0;
        for (int k = 0; k < NUM_ENTRIES; k++) begin
            hdr_done[k]  = 1'b0;
            exp_eth[k]   = eth_type_t'($urandom);
            exp_len[k]   = ip_len_t'($urandom);
            exp_proto[k] = ip_proto_t'($urandom);
            exp_src[k]   = $urandom;
            exp_dst[k]   = $urandom;
            for (int i = 0; i < MAX_LEN; i++) begin
                exp_data[k][i] = payload_byte_t'($urandom);
            end
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst = 1'b0;
        @(posedge clk);
        check_bit("in_hdr_ready", 1'b0, in_hdr_ready);
        check_bit("in_payload_tready", 1'b0, in_payload_tready);
        check_bit("out_hdr_valid", 1'b0, |out_hdr_valid);
        check_bit("out_payload_tvalid", 1'b0, |out_payload_tvalid);
        #1;
        fork
            for (int k = 0; k < NUM_ENTRIES; k++) begin
                send_frame(k);
            end
            for (int k = 0; k < NUM_ENTRIES; k++) begin
                take_frame(k);
            end
        join
        repeat (4) @(posedge clk);
        assert_errors = i_ip_demux.i_checker.fail_count;
        $display("%0d value errors, %0d protocol errors, %0d assertion errors",
                 value_errors, protocol_errors, assert_errors);
        if (value_errors + protocol_errors + assert_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== dv/ip_demux_checker.sv ====
////////////////////////////////////////////////////////////////////////////
// Handshake assertions, bound into every ip_demux instance
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ip_demux_checker (
    input logic                      clk,
    input logic                      rst,
    input logic                      in_hdr_ready,
    input logic                      in_payload_tready,
    input ip_demux_pkg::port_mask_t  out_hdr_valid,
    input ip_demux_pkg::port_mask_t  out_payload_tvalid,
    input ip_demux_pkg::port_mask_t  out_payload_tready,
    input ip_hdr_pkg::payload_byte_t out_payload_tdata,
    input logic                      out_payload_tlast,
    input logic                      out_payload_tuser
);

    int unsigned fail_count = 0;

    hdr_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(out_hdr_valid))
        else begin
            fail_count++;
            $error("out_hdr_valid has more than one bit set");
        end

    payload_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(out_payload_tvalid))
        else begin
            fail_count++;
            $error("out_payload_tvalid has more than one bit set");
        end

    // a stalled beat holds still until the sink takes it
    payload_hold: assert property (@(posedge clk) disable iff (rst)
        (|(out_payload_tvalid & ~out_payload_tready)) |=>
            $stable(out_payload_tvalid) && $stable(out_payload_tdata) &&
            $stable(out_payload_tlast) && $stable(out_payload_tuser))
        else begin
            fail_count++;
            $error("stalled payload beat changed before it was accepted");
        end

    reset_low: assert property (@(posedge clk) rst && $past(rst) |->
        !in_hdr_ready && !in_payload_tready && out_hdr_valid == '0 && out_payload_tvalid == '0)
        else begin
            fail_count++;
            $error("valid or ready high during reset");
        end

endmodule

bind ip_demux ip_demux_checker i_checker (.*);

// ==== rtl/ip_demux.sv ====
////////////////////////////////////////////////////////////////////////////
// IP frame demultiplexer, one input to four outputs, top level
// Header goes out on the select latched at frame start, payload follows
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ip_demux (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      enable,
    input  ip_demux_pkg::port_sel_t   select,

    input  logic                      in_hdr_valid,
    output logic                      in_hdr_ready,
    input  ip_hdr_pkg::eth_type_t     in_eth_type,
    input  ip_hdr_pkg::ip_len_t       in_ip_length,
    input  ip_hdr_pkg::ip_proto_t     in_ip_protocol,
    input  ip_hdr_pkg::ip_addr_t      in_ip_source_ip,
    input  ip_hdr_pkg::ip_addr_t      in_ip_dest_ip,

    input  ip_hdr_pkg::payload_byte_t in_payload_tdata,
    input  logic                      in_payload_tvalid,
    output logic                      in_payload_tready,
    input  logic                      in_payload_tlast,
    input  logic                      in_payload_tuser,

    output ip_demux_pkg::port_mask_t  out_hdr_valid,
    input  ip_demux_pkg::port_mask_t  out_hdr_ready,
    output ip_hdr_pkg::eth_type_t     out_eth_type,
    output ip_hdr_pkg::ip_len_t       out_ip_length,
    output ip_hdr_pkg::ip_proto_t     out_ip_protocol,
    output ip_hdr_pkg::ip_addr_t      out_ip_source_ip,
    output ip_hdr_pkg::ip_addr_t      out_ip_dest_ip,

    output ip_hdr_pkg::payload_byte_t out_payload_tdata,
    output ip_demux_pkg::port_mask_t  out_payload_tvalid,
    input  ip_demux_pkg::port_mask_t  out_payload_tready,
    output logic                      out_payload_tlast,
    output logic                      out_payload_tuser
);

    import ip_demux_pkg::*;

    port_sel_t port_sel;
    logic      frame_open_next;

    ip_demux_frame_ctrl i_frame_ctrl (
        .clk                (clk),
        .rst                (rst),
        .enable             (enable),
        .select             (select),
        .in_hdr_valid       (in_hdr_valid),
        .in_hdr_ready       (in_hdr_ready),
        .in_eth_type        (in_eth_type),
        .in_ip_length       (in_ip_length),
        .in_ip_protocol     (in_ip_protocol),
        .in_ip_source_ip    (in_ip_source_ip),
        .in_ip_dest_ip      (in_ip_dest_ip),
        .out_hdr_valid      (out_hdr_valid),
        .out_hdr_ready      (out_hdr_ready),
        .out_eth_type       (out_eth_type),
        .out_ip_length      (out_ip_length),
        .out_ip_protocol    (out_ip_protocol),
        .out_ip_source_ip   (out_ip_source_ip),
        .out_ip_dest_ip     (out_ip_dest_ip),
        .in_payload_tvalid  (in_payload_tvalid),
        .in_payload_tlast   (in_payload_tlast),
        .in_payload_tready  (in_payload_tready),
        .out_payload_tvalid (out_payload_tvalid),
        .port_sel           (port_sel),
        .frame_open_next    (frame_open_next)
    );

    ip_demux_payload_path i_payload_path (
        .clk                (clk),
        .rst                (rst),
        .port_sel           (port_sel),
        .frame_open_next    (frame_open_next),
        .in_payload_tdata   (in_payload_tdata),
        .in_payload_tvalid  (in_payload_tvalid),
        .in_payload_tlast   (in_payload_tlast),
        .in_payload_tuser   (in_payload_tuser),
        .in_payload_tready  (in_payload_tready),
        .out_payload_tdata  (out_payload_tdata),
        .out_payload_tvalid (out_payload_tvalid),
        .out_payload_tready (out_payload_tready),
        .out_payload_tlast  (out_payload_tlast),
        .out_payload_tuser  (out_payload_tuser)
    );

endmodule

// ==== rtl/ip_demux_payload_path.sv ====
////////////////////////////////////////////////////////////////////////////
// Payload routing through an output register and a temp skid register
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ip_demux_payload_path (
    input  logic                      clk,
    input  logic                      rst,
    input  ip_demux_pkg::port_sel_t   port_sel,
    input  logic                      frame_open_next,

    input  ip_hdr_pkg::payload_byte_t in_payload_tdata,
    input  logic                      in_payload_tvalid,
    input  logic                      in_payload_tlast,
    input  logic                      in_payload_tuser,
    output logic                      in_payload_tready,

    output ip_hdr_pkg::payload_byte_t out_payload_tdata,
    output ip_demux_pkg::port_mask_t  out_payload_tvalid,
    input  ip_demux_pkg::port_mask_t  out_payload_tready,
    output logic                      out_payload_tlast,
    output logic                      out_payload_tuser
);

    import ip_hdr_pkg::*;
    import ip_demux_pkg::*;

    // each register carries its beat's port as a mask, so a beat left over
    // from the previous frame still drains to its own output
    port_mask_t    temp_mask;
    payload_byte_t temp_tdata;
    logic          temp_tlast;
    logic          temp_tuser;

    logic          ready_int;
    logic          ready_early;
    logic          beat_valid;
    port_mask_t    beat_mask;
    logic          out_valid;
    logic          out_ready;
    logic          temp_valid;
    logic          load_out;
    logic          load_temp;
    logic          drain;

    assign beat_valid = in_payload_tvalid & in_payload_tready;
    assign beat_mask  = beat_valid ? (port_mask_t'(1) << port_sel) : '0;
    assign out_valid  = |out_payload_tvalid;
    assign out_ready  = |(out_payload_tvalid & out_payload_tready);
    assign temp_valid = |temp_mask;

    // room next cycle if the output drains, both registers are empty,
    // or the temp register stays empty this cycle
    assign ready_early = out_ready | (~temp_valid & ~out_valid) | (~temp_valid & ~beat_valid);

    assign load_out  = ready_int & (out_ready | ~out_valid);
    assign load_temp = ready_int & ~(out_ready | ~out_valid);
    assign drain     = ~ready_int & out_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ready_int          <= 1'b0;
            in_payload_tready  <= 1'b0;
            out_payload_tvalid <= '0;
            temp_mask          <= '0;
        end else begin
            ready_int         <= ready_early;
            in_payload_tready <= ready_early & frame_open_next;
            if (load_out) begin
                out_payload_tvalid <= beat_mask;
            end else if (drain) begin
                out_payload_tvalid <= temp_mask;
                temp_mask          <= '0;
            end
            if (load_temp) begin
                temp_mask <= beat_mask;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_out) begin
            out_payload_tdata <= in_payload_tdata;
            out_payload_tlast <= in_payload_tlast;
            out_payload_tuser <= in_payload_tuser;
        end else if (drain) begin
            out_payload_tdata <= temp_tdata;
            out_payload_tlast <= temp_tlast;
            out_payload_tuser <= temp_tuser;
        end
        if (load_temp) begin
            temp_tdata <= in_payload_tdata;
            temp_tlast <= in_payload_tlast;
            temp_tuser <= in_payload_tuser;
        end
    end

endmodule

// ==== rtl/ip_demux_frame_ctrl.sv ====
////////////////////////////////////////////////////////////////////////////
// Frame controller: latches the select, captures the header, tracks tlast
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ip_demux_frame_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     enable,
    input  ip_demux_pkg::port_sel_t  select,

    input  logic                     in_hdr_valid,
    output logic                     in_hdr_ready,
    input  ip_hdr_pkg::eth_type_t    in_eth_type,
    input  ip_hdr_pkg::ip_len_t      in_ip_length,
    input  ip_hdr_pkg::ip_proto_t    in_ip_protocol,
    input  ip_hdr_pkg::ip_addr_t     in_ip_source_ip,
    input  ip_hdr_pkg::ip_addr_t     in_ip_dest_ip,

    output ip_demux_pkg::port_mask_t out_hdr_valid,
    input  ip_demux_pkg::port_mask_t out_hdr_ready,
    output ip_hdr_pkg::eth_type_t    out_eth_type,
    output ip_hdr_pkg::ip_len_t      out_ip_length,
    output ip_hdr_pkg::ip_proto_t    out_ip_protocol,
    output ip_hdr_pkg::ip_addr_t     out_ip_source_ip,
    output ip_hdr_pkg::ip_addr_t     out_ip_dest_ip,

    input  logic                     in_payload_tvalid,
    input  logic                     in_payload_tlast,
    input  logic                     in_payload_tready,
    input  ip_demux_pkg::port_mask_t out_payload_tvalid,
    output ip_demux_pkg::port_sel_t  port_sel,
    output logic                     frame_open_next
);

    import ip_demux_pkg::*;

    frame_state_e state;
    frame_state_e state_next;
    port_mask_t   req_mask;
    logic         req_busy;
    logic         capture;

    assign req_mask = port_mask_t'(1) << select;

    // requested output still holds a header or a payload beat
    assign req_busy = |((out_hdr_valid | out_payload_tvalid) & req_mask);

    always_comb begin
        state_next = state;
        capture    = 1'b0;
        case (state)
            FRAME_IDLE: begin
                if (enable && in_hdr_valid && !req_busy) begin
                    capture    = 1'b1;
                    state_next = FRAME_PAYLOAD;
                end
            end
            FRAME_PAYLOAD: begin
                // end of frame on the accepted tlast beat
                if (in_payload_tvalid && in_payload_tready && in_payload_tlast) begin
                    state_next = FRAME_IDLE;
                end
            end
            default: state_next = FRAME_IDLE;
        endcase
    end

    assign frame_open_next = (state_next == FRAME_PAYLOAD);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state         <= FRAME_IDLE;
            port_sel      <= '0;
            in_hdr_ready  <= 1'b0;
            out_hdr_valid <= '0;
        end else begin
            state        <= state_next;
            in_hdr_ready <= capture;
            if (capture) begin
                port_sel <= select;
            end
            out_hdr_valid <= (out_hdr_valid & ~out_hdr_ready) | (capture ? req_mask : '0);
        end
    end

    // shared header fields, valid only under out_hdr_valid
    always_ff @(posedge clk) begin
        if (capture) begin
            out_eth_type     <= in_eth_type;
            out_ip_length    <= in_ip_length;
            out_ip_protocol  <= in_ip_protocol;
            out_ip_source_ip <= in_ip_source_ip;
            out_ip_dest_ip   <= in_ip_dest_ip;
        end
    end

endmodule

// ==== rtl/ip_demux_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Output selection types and frame state of the demultiplexer
////////////////////////////////////////////////////////////////////////////

`include "ip_demux_cfg.svh"

package ip_demux_pkg;

    // index of one output
    typedef logic [$clog2(`IP_DEMUX_NUM_OUTPUTS)-1:0] port_sel_t;

    // one bit per output, bit i is output i
    typedef logic [`IP_DEMUX_NUM_OUTPUTS-1:0] port_mask_t;

    typedef enum logic {
        FRAME_IDLE    = 1'b0,
        FRAME_PAYLOAD = 1'b1
    } frame_state_e;

endpackage

// ==== rtl/ip_hdr_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Field types of the Ethernet/IP header and of one payload beat
////////////////////////////////////////////////////////////////////////////

`include "ip_demux_cfg.svh"

package ip_hdr_pkg;

    // ethernet frame type
    typedef logic [15:0] eth_type_t;

    // ip total length in bytes
    typedef logic [15:0] ip_len_t;

    // ip protocol number
    typedef logic [7:0] ip_proto_t;

    // ipv4 address
    typedef logic [31:0] ip_addr_t;

    // one payload beat
    typedef logic [`IP_DEMUX_DATA_WIDTH-1:0] payload_byte_t;

endpackage

// ==== rtl/ip_demux_cfg.svh ====
////////////////////////////////////////////////////////////////////////////
// Size settings for the IP frame demultiplexer, included by both packages
////////////////////////////////////////////////////////////////////////////

`ifndef IP_DEMUX_CFG_SVH
`define IP_DEMUX_CFG_SVH

// number of frame outputs
`define IP_DEMUX_NUM_OUTPUTS 4

// payload beat width in bits
`define IP_DEMUX_DATA_WIDTH 8

`endif
